//--- fetch_patterns.txt
// Lines 1-8: instruction memory words 0-63 in hex, eight per line
// Then one line per phase, all hex: flush target, word count, stall percent
00000093 00100113 00200193 00300213 00400293 00500313 00600393 00700413
00800493 00900513 00a00593 00b00613 00c00693 00d00713 00e00793 00f00813
01000893 01100913 01200993 01300a13 01400a93 01500b13 01600b93 01700c13
01800c93 01900d13 01a00d93 01b00e13 01c00e93 01d00f13 01e00f93 01f00013
002081b3 00310233 004182b3 00520333 006283b3 00730433 008384b3 00940533
40208133 403101b3 40418233 405202b3 40628333 407303b3 40838433 409404b3
fe000ee3 fe101ce3 fe202ae3 fe3038e3 fe4046e3 fe5054e3 fe6062e3 fe7070e3
00008067 00110113 ff010113 00812623 00c12403 01010113 0000006f deadbeef
00000000 00000028 00000000
00000040 00000030 00000028
00000024 00000014 00000032
000000e0 00000010 00000019

//--- compile.f
hsv_core_pkg.sv
hsv_core_fetch_ctrl.sv
hsv_core_fetch_pc.sv
hsv_imem_rom.sv
hsv_core_fetch_top.sv
tb_hsv_core_fetch.sv

//--- Bender.yml
package:
  name: hsv_core_fetch

sources:
  # Design sources in compile order
  - files:
      - hsv_core_pkg.sv
      - hsv_core_fetch_ctrl.sv
      - hsv_core_fetch_pc.sv
      - hsv_imem_rom.sv
      - hsv_core_fetch_top.sv

  # Testbench, reads fetch_patterns.txt from the project root
  - target: test
    files:
      - tb_hsv_core_fetch.sv

//--- tb_hsv_core_fetch.sv
`timescale 1ns/1ps

module tb_hsv_core_fetch
  import hsv_core_pkg::*;
();

  localparam int unsigned rom_words = 64;
  localparam int unsigned num_phases = 4;
  localparam int unsigned pat_len = rom_words + 3 * num_phases;
  localparam int unsigned wait_limit = 200;
  localparam word rom_bytes = rom_words * 4;

  logic        clk_core;
  logic        rst_core_n;
  logic        flush_req;
  word         flush_target;
  logic        flush_ack;
  fetch_data_t fetch_data;
  logic        ready;
  logic        valid;
  logic        load_en;
  word         load_addr;
  word         load_data;

  // Memory image first, then target, word count and stall percent per phase
  word pat[pat_len];
  word mirror[rom_words];
  int  errors;
  int  timeouts;

  hsv_core_fetch_top #(.rom_words(rom_words)) dut_i (
    .clk_core     (clk_core),
    .rst_core_n   (rst_core_n),
    .flush_req    (flush_req),
    .flush_target (flush_target),
    .flush_ack    (flush_ack),
    .fetch_data   (fetch_data),
    .ready        (ready),
    .valid        (valid),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data)
  );

  initial begin
    clk_core = 1'b0;
    forever #5 clk_core = ~clk_core;
  end

  task automatic check_value(input word got, input word expected, input string what);
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Ready drops with the given percentage on each cycle
  task automatic drive_ready(input int unsigned stall_pct);
    ready = (($urandom % 100) >= stall_pct);
  endtask

  // Words past the end of memory come back as zero with a fault
  function automatic word expected_insn(input word addr);
    word insn;
    insn = '0;
    if (addr < rom_bytes) begin
      insn = mirror[addr >> 2];
    end
    return insn;
  endfunction

  task automatic load_memory();
    for (int unsigned i = 0; i < rom_words; i++) begin
      @(negedge clk_core);
      load_en   = 1'b1;
      load_addr = i;
      load_data = pat[i];
      mirror[i] = pat[i];
      check_value(valid, 1'b0, "valid while loading");
    end
    @(negedge clk_core);
    load_en = 1'b0;
  endtask

  task automatic request_flush(input word target, input int unsigned stall_pct, output bit ok);
    int unsigned cycles;
    ok = 1'b0;
    cycles = 0;
    @(negedge clk_core);
    flush_req    = 1'b1;
    flush_target = target;
    drive_ready(stall_pct);
    while (!ok && cycles < wait_limit) begin
      @(negedge clk_core);
      cycles++;
      if (flush_ack) begin
        ok = 1'b1;
      end else begin
        // Beats of the old stream still drain here and are dropped
        drive_ready(stall_pct);
      end
    end
    if (ok) begin
      // Nothing may be left in flight once the redirect is acknowledged
      check_value(valid, 1'b0, "valid at flush acknowledge");
      flush_req = 1'b0;
    end else begin
      timeouts++;
      $display("Timeout: flush to %h was not acknowledged within %0d cycles",
               target, wait_limit);
    end
  endtask

  task automatic collect_words(input word target, input int unsigned count,
                               input int unsigned stall_pct);
    word         exp_pc;
    int unsigned got;
    int unsigned idle;
    exp_pc = target;
    got = 0;
    idle = 0;
    while (got < count && idle < wait_limit) begin
      @(negedge clk_core);
      drive_ready(stall_pct);
      // The beat transfers on the coming rising edge, outputs are steady now
      if (valid && ready) begin
        check_value(fetch_data.pc, exp_pc, "pc");
        check_value(fetch_data.pc_increment, exp_pc + bytes_per_insn, "pc_increment");
        check_value(fetch_data.insn, expected_insn(exp_pc), "insn");
        check_value(fetch_data.fault, word'(exp_pc >= rom_bytes), "fault");
        exp_pc = exp_pc + bytes_per_insn;
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got < count) begin
      timeouts++;
      $display("Timeout: only %0d of %0d words arrived after the flush to %h",
               got, count, target);
    end
  endtask

  initial begin
    bit          ok;
    word         target;
    int unsigned count;
    int unsigned stall;

    void'($urandom(51961));
    errors       = 0;
    timeouts     = 0;
    rst_core_n   = 1'b0;
    flush_req    = 1'b0;
    flush_target = '0;
    ready        = 1'b0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;

    $readmemh("fetch_patterns.txt", pat);

    repeat (3) @(negedge clk_core);
    rst_core_n = 1'b1;

    @(negedge clk_core);
    check_value(flush_ack, 1'b1, "flush_ack after reset");
    check_value(valid, 1'b0, "valid after reset");

    if ($isunknown(pat[pat_len-1])) begin
      errors++;
      $display("The pattern file fetch_patterns.txt is missing or too short");
    end else begin
      load_memory();
      // Every flush after the first one lands while bursts are still outstanding
      for (int unsigned p = 0; p < num_phases && timeouts == 0; p++) begin
        target = pat[rom_words + 3 * p];
        count  = pat[rom_words + 3 * p + 1];
        stall  = pat[rom_words + 3 * p + 2];
        request_flush(target, stall, ok);
        if (ok) begin
          collect_words(target, count, stall);
        end
      end
    end

    $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- hsv_core_fetch_top.sv
`timescale 1ns/1ps

module hsv_core_fetch_top
  import hsv_core_pkg::*;
#(
  parameter int unsigned rom_words = 64
) (
  input  logic        clk_core,
  input  logic        rst_core_n,

  input  logic        flush_req,
  input  word         flush_target,
  output logic        flush_ack,

  output fetch_data_t fetch_data,
  input  logic        ready,
  output logic        valid,

  input  logic        load_en,
  input  word         load_addr,
  input  word         load_data
);

  axi_ar_t ar;
  axi_r_t  r;
  logic    ar_valid, ar_ready, r_valid;
  logic    fetch_start, fetch_beat;
  word     burst_base, pc, pc_increment;

  // Every request is one INCR burst of word-sized beats
  assign ar.addr  = burst_base;
  assign ar.len   = 8'(burst_len - 32'd1);
  assign ar.size  = axi_size_4;
  assign ar.burst = AXI_BURST_INCR;

  assign valid = r_valid;

  assign fetch_data.pc           = pc;
  assign fetch_data.insn         = r.data;
  assign fetch_data.pc_increment = pc_increment;
  assign fetch_data.fault        = is_axi_error(r.resp);

  hsv_core_fetch_ctrl ctrl_i (
    .clk_core    (clk_core),
    .rst_core_n  (rst_core_n),
    .flush_req   (flush_req),
    .flush_ack   (flush_ack),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .r_valid     (r_valid),
    .r_ready     (ready),
    .r_last      (r.last),
    .fetch_start (fetch_start),
    .fetch_beat  (fetch_beat)
  );

  hsv_core_fetch_pc pc_i (
    .clk_core     (clk_core),
    .flush_req    (flush_req),
    .flush_target (flush_target),
    .flush_ack    (flush_ack),
    .fetch_start  (fetch_start),
    .fetch_beat   (fetch_beat),
    .burst_base   (burst_base),
    .pc           (pc),
    .pc_increment (pc_increment)
  );

  hsv_imem_rom #(.rom_words(rom_words)) imem_i (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_valid    (r_valid),
    .r_ready    (ready)
  );

endmodule

//--- hsv_imem_rom.sv
`timescale 1ns/1ps

module hsv_imem_rom
  import hsv_core_pkg::*;
#(
  parameter int unsigned rom_words = 64
) (
  input  logic    clk_core,
  input  logic    rst_core_n,

  input  logic    load_en,
  input  word     load_addr,
  input  word     load_data,

  input  axi_ar_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,

  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready
);

  localparam int unsigned idx_w = $clog2(rom_words);
  localparam word rom_bytes = word'(rom_words) * bytes_per_insn;

  word        mem[rom_words];
  axi_ar_t    queue[2];
  logic [1:0] q_count;
  logic [7:0] beat_cnt;

  logic       push, pop, load_beat;
  logic [7:0] nxt_idx;
  axi_ar_t    nxt_req;
  word        nxt_addr;

  assign ar_ready = (q_count != 2'd2);
  assign push     = ar_valid && ar_ready;
  assign pop      = r_valid && r_ready && r.last;

  // Decide whether the output register takes a new beat and which one
  always_comb begin
    load_beat = 1'b0;
    nxt_idx   = 8'd0;
    nxt_req   = queue[0];
    if (r_valid && !r.last) begin
      load_beat = r_ready;
      nxt_idx   = beat_cnt + 8'd1;
    end else if (pop) begin
      // Chain straight into the queued burst without a bubble
      load_beat = (q_count == 2'd2);
      nxt_req   = queue[1];
    end else if (!r_valid) begin
      load_beat = (q_count != 2'd0);
    end
  end

  assign nxt_addr = nxt_req.addr + (word'(nxt_idx) << 2);

  always_ff @(posedge clk_core) begin
    if (load_en && load_addr < word'(rom_words)) begin
      mem[load_addr[idx_w-1:0]] <= load_data;
    end
  end

  // Head of the queue is the burst being served, shift on its last beat
  always_ff @(posedge clk_core) begin
    if (pop) begin
      queue[0] <= queue[1];
    end
    if (push) begin
      if (q_count == 2'd1 && !pop) queue[1] <= ar;
      else queue[0] <= ar;
    end
  end

  always_ff @(posedge clk_core) begin
    if (load_beat) begin
      r.last <= (nxt_idx == nxt_req.len);
      if (nxt_addr < rom_bytes) begin
        r.data <= mem[nxt_addr[idx_w+1:2]];
        r.resp <= AXI_RESP_OKAY;
      end else begin
        r.data <= '0;
        r.resp <= AXI_RESP_SLVERR;
      end
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      r_valid  <= 1'b0;
      beat_cnt <= 8'd0;
      q_count  <= 2'd0;
    end else begin
      if (load_beat) begin
        r_valid  <= 1'b1;
        beat_cnt <= nxt_idx;
      end else if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
      q_count <= q_count + 2'(push) - 2'(pop);
    end
  end

  a_queue_bound : assert property (
    @(posedge clk_core) disable iff (!rst_core_n) q_count != 2'd3);

  a_r_stable : assert property (
    @(posedge clk_core) disable iff (!rst_core_n)
    r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

//--- hsv_core_fetch_pc.sv
`timescale 1ns/1ps

module hsv_core_fetch_pc
  import hsv_core_pkg::*;
(
  input  logic clk_core,

  input  logic flush_req,
  input  word  flush_target,
  input  logic flush_ack,

  input  logic fetch_start,
  input  logic fetch_beat,

  output word  burst_base,
  output word  pc,
  output word  pc_increment
);

  localparam word burst_bytes = burst_len * bytes_per_insn;

  logic flush_release;

  // The cycle the outside drops its request while the FSM still acknowledges
  assign flush_release = !flush_req && flush_ack;

  always_ff @(posedge clk_core) begin
    // Next burst starts right after the one just requested
    if (fetch_start) begin
      burst_base <= burst_base + burst_bytes;
    end

    if (fetch_beat) begin
      pc <= pc_increment;
    end

    // The extra step on release puts pc_increment one word ahead of pc
    if (fetch_beat || flush_release) begin
      pc_increment <= pc_increment + bytes_per_insn;
    end

    // A redirect overrides every other update
    if (flush_req) begin
      burst_base   <= flush_target;
      pc           <= flush_target;
      pc_increment <= flush_target;
    end
  end

  a_pc_step : assert property (
    @(posedge clk_core) fetch_beat && !flush_req |-> pc_increment - pc == bytes_per_insn);

endmodule

//--- hsv_core_fetch_ctrl.sv
`timescale 1ns/1ps

module hsv_core_fetch_ctrl (
  input  logic clk_core,
  input  logic rst_core_n,

  input  logic flush_req,
  output logic flush_ack,

  output logic ar_valid,
  input  logic ar_ready,

  input  logic r_valid,
  input  logic r_ready,
  input  logic r_last,

  output logic fetch_start,
  output logic fetch_beat
);

  // The state counts how many accepted bursts are still unfinished
  typedef enum logic [1:0] {
    FLUSH,
    FETCH_0,
    FETCH_1,
    FETCH_2
  } state_t;

  state_t state, next_state;
  logic   fetch_end;
  logic   flush_armed;

  assign fetch_start = ar_valid & ar_ready;
  assign fetch_beat  = r_valid & r_ready;
  assign fetch_end   = fetch_beat & r_last;

  always_comb begin
    flush_ack = 1'b0;
    ar_valid  = 1'b0;

    case (state)
      FLUSH:   flush_ack = 1'b1;
      FETCH_0: ar_valid = 1'b1;
      FETCH_1: ar_valid = 1'b1;
      // Two bursts in flight, wait for one to finish
      default: ;
    endcase

    // A pending redirect stops new requests so the old stream can drain
    if (flush_req) begin
      ar_valid = 1'b0;
    end

    next_state = state;
    case (state)
      FLUSH: begin
        if (!flush_req && flush_armed) next_state = FETCH_0;
      end
      FETCH_0: begin
        if (flush_req) next_state = FLUSH;
        else if (fetch_start) next_state = FETCH_1;
      end
      FETCH_1: begin
        if (fetch_start && !fetch_end) next_state = FETCH_2;
        else if (!fetch_start && fetch_end) next_state = FETCH_0;
      end
      default: begin
        if (fetch_end) next_state = FETCH_1;
      end
    endcase
  end

  // Fetch only starts once a target has been supplied through a flush
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state       <= FLUSH;
      flush_armed <= 1'b0;
    end else begin
      state <= next_state;
      if (state == FLUSH && flush_req) begin
        flush_armed <= 1'b1;
      end
    end
  end

  // The memory has no beat left to deliver once a redirect is acknowledged
  a_drained_at_ack : assert property (
    @(posedge clk_core) disable iff (!rst_core_n) flush_ack |-> !r_valid);

  a_no_end_when_idle : assert property (
    @(posedge clk_core) disable iff (!rst_core_n) fetch_end |-> state != FETCH_0);

endmodule

//--- hsv_core_pkg.sv
package hsv_core_pkg;

  // One instruction word, also used for byte addresses
  typedef logic [31:0] word;

  // Each prefetch request asks for this many consecutive instruction words
  localparam word burst_len = 32'd8;
  localparam word bytes_per_insn = 32'd4;

  // Encoding of the AxSIZE field for four-byte beats
  localparam logic [2:0] axi_size_4 = 3'd2;

  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
  } axi_resp_t;

  // Only INCR bursts are issued by the fetch unit
  typedef enum logic [1:0] {
    AXI_BURST_FIXED = 2'b00,
    AXI_BURST_INCR  = 2'b01,
    AXI_BURST_WRAP  = 2'b10
  } axi_burst_t;

  // Read address channel payload
  typedef struct packed {
    word        addr;
    logic [7:0] len;
    logic [2:0] size;
    axi_burst_t burst;
  } axi_ar_t;

  // Read data channel payload, one beat
  typedef struct packed {
    word       data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  // What the fetch unit hands to decode for every instruction
  typedef struct packed {
    word  pc;
    word  insn;
    word  pc_increment;
    logic fault;
  } fetch_data_t;

  // Slave and decode errors both turn into an instruction fault
  function automatic logic is_axi_error(axi_resp_t resp);
    logic err;
    err = 1'b0;
    if (resp == AXI_RESP_SLVERR || resp == AXI_RESP_DECERR) begin
      err = 1'b1;
    end
    return err;
  endfunction

endpackage
